// File: rv_data_ram.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module rv_data_ram import rv_lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [`RAM_ADDR_WIDTH-1:0] wb_adr,
  input  logic [3:0]                 wb_sel,
  input  lsu_word_u                  wb_dat_w,
  output logic                       wb_ack,
  output lsu_word_u                  wb_dat_r
);

  localparam int DEPTH = 1 << `RAM_ADDR_WIDTH;
  localparam int LANES = `DATA_WIDTH / 8;

  lsu_word_u mem [0:DEPTH-1];
  logic      access;

  // first cycle of a strobe, ack not yet given
  assign access = wb_cyc & wb_stb & ~wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access; // one pulse per strobe
    end
  end

  always_ff @(posedge clk) begin
    if (access && wb_we) begin
      for (int i = 0; i < LANES; i++) begin
        if (wb_sel[i]) mem[wb_adr].bytes[i] <= wb_dat_w.bytes[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      wb_dat_r <= mem[wb_adr]; // valid with ack
    end
  end

endmodule

// File: rv_load_extract.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module rv_load_extract import rv_lsu_pkg::*; (
  input  logic [2:0]             funct3,
  input  logic [1:0]             addr_low,
  input  lsu_word_u              rd_word,
  output logic [`DATA_WIDTH-1:0] load_value,
  output logic                   misaligned
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign byte_sel = rd_word.bytes[addr_low];
  assign half_sel = addr_low[1] ? {rd_word.bytes[3], rd_word.bytes[2]}
                                : {rd_word.bytes[1], rd_word.bytes[0]};

  always_comb begin
    case (funct3)
      3'b000:  load_value = {{(`DATA_WIDTH-8){byte_sel[7]}}, byte_sel};   // lb
      3'b001:  load_value = {{(`DATA_WIDTH-16){half_sel[15]}}, half_sel}; // lh
      3'b010:  load_value = rd_word.word;                                 // lw
      3'b100:  load_value = {{(`DATA_WIDTH-8){1'b0}}, byte_sel};          // lbu
      3'b101:  load_value = {{(`DATA_WIDTH-16){1'b0}}, half_sel};         // lhu
      default: load_value = '0;
    endcase
  end

  // same width rule as the store side
  always_comb begin
    case (funct3[1:0])
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = addr_low[0];
      default: misaligned = |addr_low;
    endcase
  end

endmodule

// File: rv_lsu.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module rv_lsu import rv_lsu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  logic [`LSU_OPT_WIDTH-1:0]  lsu_opt,
  input  logic [2:0]                 funct3,
  input  logic [`DATA_WIDTH-1:0]     addr,
  input  logic [`DATA_WIDTH-1:0]     src2,
  output logic                       busy,
  output logic                       done,
  output logic                       err,
  output logic [`DATA_WIDTH-1:0]     lsu_result,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [`RAM_ADDR_WIDTH-1:0] wb_adr,
  output logic [3:0]                 wb_sel,
  output lsu_word_u                  wb_dat_w,
  input  logic                       wb_ack,
  input  lsu_word_u                  wb_dat_r
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_CHECK = 2'd1;
  localparam logic [1:0] ST_BUS   = 2'd2;

  logic [1:0]                  state;
  logic [`LSU_OPT_WIDTH-1:0]   opt_q;
  logic [2:0]                  funct3_q;
  logic [`RAM_ADDR_WIDTH+1:0]  addr_q;
  lsu_word_u                   st_word;
  lsu_word_u                   st_word_q;
  logic [3:0]                  st_sel;
  logic [3:0]                  st_sel_q;
  logic                        st_mis;
  logic                        st_mis_q;
  logic [`DATA_WIDTH-1:0]      ld_value;
  logic                        ld_mis;
  logic                        accept;
  logic                        is_load;
  logic                        is_store;
  logic                        bad_access;

  rv_store_align u_store_align (
    .funct3     (funct3),
    .addr_low   (addr[1:0]),
    .src2       (src2),
    .wr_word    (st_word),
    .wr_sel     (st_sel),
    .misaligned (st_mis)
  );

  rv_load_extract u_load_extract (
    .funct3     (funct3_q),
    .addr_low   (addr_q[1:0]),
    .rd_word    (wb_dat_r),
    .load_value (ld_value),
    .misaligned (ld_mis)
  );

  assign busy     = (state != ST_IDLE);
  assign accept   = req_valid & ~busy;
  assign is_load  = (opt_q == `LSU_OPT_LOAD);
  assign is_store = (opt_q == `LSU_OPT_STORE);
  // unknown op code also ends in error
  assign bad_access = is_load  ? ld_mis :
                      is_store ? st_mis_q : (opt_q != `LSU_OPT_NONE);

  assign wb_adr   = addr_q[`RAM_ADDR_WIDTH+1:2];
  assign wb_sel   = wb_we ? st_sel_q : 4'b1111; // reads fetch the whole word
  assign wb_dat_w = st_word_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      opt_q     <= lsu_opt;
      funct3_q  <= funct3;
      addr_q    <= addr[`RAM_ADDR_WIDTH+1:0];
      st_word_q <= st_word;
      st_sel_q  <= st_sel;
      st_mis_q  <= st_mis;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      done   <= 1'b0;
      err    <= 1'b0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      done <= 1'b0;
      err  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) state <= ST_CHECK;
        end
        ST_CHECK: begin
          if (opt_q == `LSU_OPT_NONE || bad_access) begin // no bus cycle
            done  <= 1'b1;
            err   <= bad_access;
            state <= ST_IDLE;
          end else begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= is_store;
            state  <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b1;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_CHECK) begin
      lsu_result <= '0;
    end else if (state == ST_BUS && wb_ack) begin
      lsu_result <= is_load ? ld_value : '0; // stores return zero
    end
  end

endmodule

// File: rv_lsu_chk.sv
`timescale 1ns/1ps

module rv_lsu_chk (
  input logic       clk,
  input logic       rst,
  input logic       done,
  input logic       err,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic [3:0] wb_sel,
  input logic       wb_ack
);

  int unsigned fail_count = 0; // read by the testbench at the end

  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done high on two consecutive cycles");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) wb_cyc == wb_stb)
    else begin
      $error("wishbone cyc and stb differ");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_sel != 4'b0000)
    else begin
      $error("strobe with empty byte select");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) err |-> !wb_cyc)
    else begin
      $error("bus cycle while err is high");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
    else begin
      $error("ack without strobe");
      fail_count++;
    end

endmodule

bind rv_lsu rv_lsu_chk u_chk (.*);

// File: rv_lsu_defines.svh
`ifndef RV_LSU_DEFINES_SVH
`define RV_LSU_DEFINES_SVH

// address and data width of the core
`define DATA_WIDTH 32

// operation code of the lsu request
`define LSU_OPT_WIDTH 2

`define LSU_OPT_NONE  2'd0 // no memory access
`define LSU_OPT_LOAD  2'd1 // lb lh lw lbu lhu
`define LSU_OPT_STORE 2'd2 // sb sh sw

// word address bits of the data ram, 256 words
`define RAM_ADDR_WIDTH 8

`endif

// File: rv_lsu_golden.txt
// op funct3 addr store_data exp_result exp_err, all in hex
// op 0 none, 1 load, 2 store; funct3 as in the RISC-V encoding
2 2 00000000 12345678 00000000 0
2 2 00000004 cafef00d 00000000 0
1 2 00000000 00000000 12345678 0
1 2 00000004 00000000 cafef00d 0
2 2 00000010 11111111 00000000 0
2 0 00000010 000000a1 00000000 0
2 0 00000012 00000083 00000000 0
1 2 00000010 00000000 118311a1 0
2 0 00000011 ffffffb2 00000000 0
2 0 00000013 123456f4 00000000 0
1 2 00000010 00000000 f483b2a1 0
2 2 00000020 22222222 00000000 0
2 1 00000022 9abc8765 00000000 0
2 1 00000020 0000fe01 00000000 0
1 2 00000020 00000000 8765fe01 0
1 0 00000010 00000000 ffffffa1 0
1 4 00000010 00000000 000000a1 0
1 0 00000013 00000000 fffffff4 0
1 0 00000004 00000000 0000000d 0
1 1 00000020 00000000 fffffe01 0
1 1 00000022 00000000 ffff8765 0
1 5 00000012 00000000 0000f483 0
1 1 00000011 00000000 00000000 1
2 1 00000023 0000ffff 00000000 1
1 2 00000005 00000000 00000000 1
2 2 00000001 ffffffff 00000000 1
1 2 00000000 00000000 12345678 0
1 2 00000020 00000000 8765fe01 0
0 0 00000040 00000000 00000000 0

// File: rv_lsu_pkg.sv
`include "rv_lsu_defines.svh"

package rv_lsu_pkg;

  // one bus word, as a whole or as byte lanes (lane 0 lowest)
  typedef union packed {
    logic [`DATA_WIDTH-1:0]          word;
    logic [`DATA_WIDTH/8-1:0][7:0]   bytes;
  } lsu_word_u;

endpackage

// File: rv_lsu_top.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module rv_lsu_top import rv_lsu_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_valid,
  input  logic [`LSU_OPT_WIDTH-1:0] lsu_opt,
  input  logic [2:0]                funct3,
  input  logic [`DATA_WIDTH-1:0]    addr,
  input  logic [`DATA_WIDTH-1:0]    src2,
  output logic                      busy,
  output logic                      done,
  output logic                      err,
  output logic [`DATA_WIDTH-1:0]    lsu_result
);

  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [`RAM_ADDR_WIDTH-1:0] wb_adr;
  logic [3:0]                 wb_sel;
  lsu_word_u                  wb_dat_w;
  logic                       wb_ack;
  lsu_word_u                  wb_dat_r;

  rv_lsu u_lsu (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .lsu_opt    (lsu_opt),
    .funct3     (funct3),
    .addr       (addr),
    .src2       (src2),
    .busy       (busy),
    .done       (done),
    .err        (err),
    .lsu_result (lsu_result),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_sel     (wb_sel),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .wb_dat_r   (wb_dat_r)
  );

  rv_data_ram u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

endmodule

// File: rv_store_align.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module rv_store_align import rv_lsu_pkg::*; (
  input  logic [2:0]             funct3,
  input  logic [1:0]             addr_low,
  input  logic [`DATA_WIDTH-1:0] src2,
  output lsu_word_u              wr_word,
  output logic [3:0]             wr_sel,
  output logic                   misaligned
);

  localparam int LANES = `DATA_WIDTH / 8;

  always_comb begin
    wr_word    = '0;
    wr_sel     = '0;
    misaligned = 1'b0;
    case (funct3[1:0]) // width only, sign bit ignored
      2'b00: begin // sb
        for (int i = 0; i < LANES; i++) begin
          wr_word.bytes[i] = src2[7:0];
        end
        wr_sel = 4'b0001 << addr_low;
      end
      2'b01: begin // sh
        for (int i = 0; i < LANES; i++) begin
          wr_word.bytes[i] = i[0] ? src2[15:8] : src2[7:0];
        end
        wr_sel     = addr_low[1] ? 4'b1100 : 4'b0011;
        misaligned = addr_low[0]; // odd halfword
      end
      default: begin // sw
        wr_word.word = src2;
        wr_sel       = 4'b1111;
        misaligned   = |addr_low;
      end
    endcase
  end

endmodule

// File: tb.f
+incdir+.
rv_lsu_pkg.sv
rv_store_align.sv
rv_load_extract.sv
rv_lsu.sv
rv_data_ram.sv
rv_lsu_top.sv
rv_lsu_chk.sv
tb_rv_lsu.sv

// File: tb_rv_lsu.sv
`timescale 1ns/1ps
`include "rv_lsu_defines.svh"

module tb_rv_lsu import rv_lsu_pkg::*; ();

  localparam int TIMEOUT   = 50;
  localparam int MEM_BYTES = 4 << `RAM_ADDR_WIDTH;

  logic                      clk = 1'b0;
  logic                      rst = 1'b1;
  logic                      req_valid = 1'b0;
  logic [`LSU_OPT_WIDTH-1:0] lsu_opt = '0;
  logic [2:0]                funct3 = '0;
  logic [`DATA_WIDTH-1:0]    addr = '0;
  logic [`DATA_WIDTH-1:0]    src2 = '0;
  logic                      busy;
  logic                      done;
  logic                      err;
  logic [`DATA_WIDTH-1:0]    lsu_result;
  logic [7:0]                ref_mem [0:MEM_BYTES-1]; // byte model of the ram
  integer                    seed = 32'hc239e4ee;
  int                        accepts = 0;
  int                        dones = 0;
  logic                      counting = 1'b0;

  rv_lsu_top rv_lsu_top_i (.*);

  always #4 clk = ~clk;

  // negedge sampling, values settled between edges
  always @(negedge clk) begin
    if (counting && req_valid && !busy) accepts++;
    if (counting && done) dones++;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input lsu_word_u got, input lsu_word_u exp);
    if (got !== exp) stop_with_error($sformatf("FAILED at %0t ns: %s is %h, expected %h",
      $time, name, got.word, exp.word));
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) stop_with_error($sformatf("FAILED at %0t ns: %s is %b, expected %b",
      $time, name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) stop_with_error($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
      $time, name, got, exp));
  endtask

  task automatic wait_idle();
    int n = 0;
    while (busy) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_with_error("timeout while waiting for busy to drop");
    end
  endtask

  task automatic wait_done();
    int n = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) stop_with_error("timeout while waiting for done");
    end
  endtask

  // one request for one cycle, returns with done high
  task automatic run_request(input logic [1:0] op, input logic [2:0] f3,
                             input logic [31:0] a, input logic [31:0] d);
    wait_idle();
    req_valid = 1'b1;
    lsu_opt   = op;
    funct3    = f3;
    addr      = a;
    src2      = d;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    wait_done();
  endtask

  task automatic update_model(input logic [31:0] a, input logic [2:0] f3, input logic [31:0] d);
    int nbytes;
    nbytes = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[(a + i) % MEM_BYTES] = d[8*i +: 8];
    end
  endtask

  function automatic lsu_word_u model_word(input logic [31:0] a);
    lsu_word_u w;
    for (int i = 0; i < 4; i++) begin
      w.bytes[i] = ref_mem[(a + i) % MEM_BYTES];
    end
    return w;
  endfunction

  initial begin
    int          fd;
    int          entries;
    string       line;
    logic [31:0] op, f3, a, d, exp_res, exp_err;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    check_err("busy", busy, 1'b0);
    check_err("done", done, 1'b0);
    check_err("err", err, 1'b0);

    fd = $fopen("rv_lsu_golden.txt", "r");
    if (fd == 0) stop_with_error("cannot open rv_lsu_golden.txt");
    entries = 0;
    while ($fgets(line, fd)) begin
      if ($sscanf(line, "%h %h %h %h %h %h", op, f3, a, d, exp_res, exp_err) == 6) begin
        run_request(op[1:0], f3[2:0], a, d);
        check_err("err", err, exp_err[0]);
        check_result("lsu_result", lsu_result, exp_res);
        if (op[1:0] == `LSU_OPT_STORE && !exp_err[0]) update_model(a, f3[2:0], d);
        entries++;
      end
    end
    $fclose(fd);
    if (entries == 0) stop_with_error("no requests found in rv_lsu_golden.txt");

    // word accesses at offsets 2 and 3
    for (int off = 2; off < 4; off++) begin
      run_request(`LSU_OPT_LOAD, 3'b010, 32'h4 + off, 32'h0);
      check_err("err", err, 1'b1);
      check_result("lsu_result", lsu_result, 32'h0);
      run_request(`LSU_OPT_STORE, 3'b010, 32'h4 + off, 32'hffffffff);
      check_err("err", err, 1'b1);
      check_result("lsu_result", lsu_result, 32'h0);
    end
    run_request(`LSU_OPT_LOAD, 3'b010, 32'h4, 32'h0);
    check_err("err", err, 1'b0);
    check_result("lsu_result", lsu_result, model_word(32'h4));

    @(posedge clk); // last done pulse ends here
    #1;
    // req_valid held high for 12 cycles
    counting  = 1'b1;
    req_valid = 1'b1;
    lsu_opt   = `LSU_OPT_LOAD;
    funct3    = 3'b010;
    addr      = '0;
    repeat (12) @(posedge clk);
    #1;
    req_valid = 1'b0;
    wait_idle();
    @(negedge clk);
    #1;
    counting = 1'b0;
    check_count("done count", dones, accepts);
    check_count("accepted requests", accepts, 3); // one access per four cycles

    for (int i = 0; i < 20; i++) begin
      a = ({$random(seed)} % (1 << `RAM_ADDR_WIDTH)) * 4;
      d = $random(seed);
      run_request(`LSU_OPT_STORE, 3'b010, a, d);
      check_err("err", err, 1'b0);
      update_model(a, 3'b010, d);
      run_request(`LSU_OPT_LOAD, 3'b010, a, 32'h0);
      check_err("err", err, 1'b0);
      check_result("lsu_result", lsu_result, model_word(a));
    end

    if (rv_lsu_top_i.u_lsu.u_chk.fail_count != 0) begin
      stop_with_error("protocol assertions failed during the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
